/* source/cache_pkg.sv */
package cache_pkg;

    //////////////////////////////
    // Address geometry
    //////////////////////////////
    localparam int addr_width   = 30;
    localparam int tag_width    = 20;
    localparam int index_width  = 7;
    localparam int offset_width = 3;

    // Line and memory bus geometry
    localparam int words_per_line   = 1 << offset_width;
    localparam int block_bits       = 32 * words_per_line;
    localparam int block_addr_width = tag_width + index_width;

    // Field view of a word address
    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } cache_addr_fields_t;

    // Same 30 bits, read raw or split into fields
    typedef union packed {
        logic [addr_width-1:0] word;
        cache_addr_fields_t    f;
    } cache_addr_t;

endpackage

/* source/cache_word_ram.sv */
module cache_word_ram (
    input  logic                              clk,
    input  logic                              we,
    input  logic [3:0]                        byte_en,
    input  logic [cache_pkg::index_width-1:0] index,
    input  logic [31:0]                       wdata,
    output logic [31:0]                       rdata
);

    localparam int depth = 1 << cache_pkg::index_width;

    logic [31:0] mem [depth];

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Lookup reads in the same cycle
    assign rdata = mem[index];

endmodule

/* source/cache_line_store.sv */
module cache_line_store (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_pkg::cache_addr_t           addr,
    input  logic                             word_we,
    input  logic [3:0]                       byte_en,
    input  logic [31:0]                      wdata,
    input  logic                             fill,
    input  logic [cache_pkg::block_bits-1:0] fill_block,
    output logic                             hit,
    output logic                             valid,
    output logic                             dirty,
    output logic [cache_pkg::tag_width-1:0]  victim_tag,
    output logic [31:0]                      rdata,
    output logic [cache_pkg::block_bits-1:0] line_block
);

    localparam int depth = 1 << cache_pkg::index_width;

    logic [cache_pkg::tag_width-1:0] tags [depth];
    logic [depth-1:0]                valid_bits;
    logic [depth-1:0]                dirty_bits;
    logic [31:0]                     words [cache_pkg::words_per_line];
    logic                            word_write;

    //////////////////////////////
    // Tag match
    //////////////////////////////
    assign valid      = valid_bits[addr.f.index];
    assign dirty      = dirty_bits[addr.f.index];
    assign victim_tag = tags[addr.f.index];
    assign hit        = valid && (victim_tag == addr.f.tag);

    // Core writes land only on a matching line
    assign word_write = word_we && hit;

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[addr.f.index] <= addr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill) begin
            valid_bits[addr.f.index] <= 1'b1;
            dirty_bits[addr.f.index] <= 1'b0;
        end else if (word_write) begin
            dirty_bits[addr.f.index] <= 1'b1;
        end
    end

    //////////////////////////////
    // Data columns
    //////////////////////////////
    for (genvar i = 0; i < cache_pkg::words_per_line; i++) begin : g_word
        logic        col_we;
        logic [3:0]  col_be;
        logic [31:0] col_wdata;

        // Fill writes the whole column set with all bytes
        assign col_we    = fill ||
                           (word_write && addr.f.offset == cache_pkg::offset_width'(i));
        assign col_be    = fill ? 4'b1111 : byte_en;
        assign col_wdata = fill ? fill_block[i*32 +: 32] : wdata;

        cache_word_ram u_ram (
            .clk     (clk),
            .we      (col_we),
            .byte_en (col_be),
            .index   (addr.f.index),
            .wdata   (col_wdata),
            .rdata   (words[i])
        );

        assign line_block[i*32 +: 32] = words[i];
    end

    // Word select for the core
    assign rdata = words[addr.f.offset];

endmodule

/* source/cache_ctrl.sv */
module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,

    // Core side
    input  logic                                   req,
    input  logic                                   we,
    input  logic [3:0]                             byte_en,
    input  logic [cache_pkg::addr_width-1:0]       addr,
    input  logic [31:0]                            wdata,
    output logic                                   done,
    output logic [31:0]                            rdata,

    // Memory side
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [cache_pkg::block_addr_width-1:0] mem_addr,
    output logic [cache_pkg::block_bits-1:0]       mem_wblock,
    input  logic                                   mem_done,
    input  logic [cache_pkg::block_bits-1:0]       mem_rblock
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill
    } state_t;

    state_t state;
    state_t state_next;

    // Captured request
    cache_pkg::cache_addr_t addr_q;
    logic                   we_q;
    logic [3:0]             byte_en_q;
    logic [31:0]            wdata_q;

    // Line store view
    logic                            hit;
    logic                            line_valid;
    logic                            line_dirty;
    logic [cache_pkg::tag_width-1:0] victim_tag;
    logic                            word_we;
    logic                            fill;

    //////////////////////////////
    // State machine
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            addr_q.word <= addr;
            we_q        <= we;
            byte_en_q   <= byte_en;
            wdata_q     <= wdata;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      if (req) state_next = st_lookup;
            st_lookup: begin
                if (hit) begin
                    state_next = st_idle;
                end else if (line_valid && line_dirty) begin
                    state_next = st_writeback;
                end else begin
                    state_next = st_refill;
                end
            end
            st_writeback: if (mem_done) state_next = st_refill;
            st_refill:    if (mem_done) state_next = st_lookup;
            default:      state_next = st_idle;
        endcase
    end

    // Hit path completes in the lookup cycle
    assign done    = (state == st_lookup) && hit;
    assign word_we = (state == st_lookup) && we_q;
    assign fill    = (state == st_refill) && mem_done;

    //////////////////////////////
    // Memory bus
    //////////////////////////////
    assign mem_req  = (state == st_writeback) || (state == st_refill);
    assign mem_we   = (state == st_writeback);
    // Victim goes out under its own tag, refill under the request tag
    assign mem_addr = (state == st_writeback) ? {victim_tag, addr_q.f.index}
                                              : {addr_q.f.tag, addr_q.f.index};

    cache_line_store u_store (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr_q),
        .word_we    (word_we),
        .byte_en    (byte_en_q),
        .wdata      (wdata_q),
        .fill       (fill),
        .fill_block (mem_rblock),
        .hit        (hit),
        .valid      (line_valid),
        .dirty      (line_dirty),
        .victim_tag (victim_tag),
        .rdata      (rdata),
        .line_block (mem_wblock)
    );

    // Memory answers only a transfer this cache has pending
    a_mem_done_with_req: assert property (@(posedge clk) disable iff (rst)
        mem_done |-> mem_req)
        else $error("mem_done arrived with no memory request pending");

    // A refilled line hits on the next lookup
    a_refill_hits: assert property (@(posedge clk) disable iff (rst)
        fill |=> done)
        else $error("refilled line missed on the following lookup");

endmodule

/* source/mem_arbiter.sv */
module mem_arbiter (
    input  logic                                   clk,
    input  logic                                   rst,

    // Cache 0
    input  logic                                   cache0_req,
    input  logic                                   cache0_we,
    input  logic [cache_pkg::block_addr_width-1:0] cache0_addr,
    input  logic [cache_pkg::block_bits-1:0]       cache0_wblock,
    output logic                                   cache0_done,
    output logic [cache_pkg::block_bits-1:0]       cache0_rblock,

    // Cache 1
    input  logic                                   cache1_req,
    input  logic                                   cache1_we,
    input  logic [cache_pkg::block_addr_width-1:0] cache1_addr,
    input  logic [cache_pkg::block_bits-1:0]       cache1_wblock,
    output logic                                   cache1_done,
    output logic [cache_pkg::block_bits-1:0]       cache1_rblock,

    // Toward main memory
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [cache_pkg::block_addr_width-1:0] mem_addr,
    output logic [cache_pkg::block_bits-1:0]       mem_wblock,
    input  logic                                   mem_done,
    input  logic [cache_pkg::block_bits-1:0]       mem_rblock
);

    logic busy;
    logic grant;
    logic prio;
    logic pick;

    // prio names the cache that wins a tie
    assign pick = (cache0_req && cache1_req) ? prio : cache1_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            grant <= 1'b0;
            prio  <= 1'b0;
        end else if (!busy) begin
            if (cache0_req || cache1_req) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (mem_done) begin
            busy <= 1'b0;
            prio <= ~grant;
        end
    end

    assign mem_req    = busy && (grant ? cache1_req : cache0_req);
    assign mem_we     = grant ? cache1_we : cache0_we;
    assign mem_addr   = grant ? cache1_addr : cache0_addr;
    assign mem_wblock = grant ? cache1_wblock : cache0_wblock;

    // Responses go to the owner only
    assign cache0_done   = busy && !grant && mem_done;
    assign cache1_done   = busy && grant && mem_done;
    assign cache0_rblock = grant ? '0 : mem_rblock;
    assign cache1_rblock = grant ? mem_rblock : '0;

    // Owner keeps its request and the grant until memory answers
    a_grant_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_done |=> mem_req && $stable(grant))
        else $error("grant or owner request changed during a memory transfer");

endmodule

/* source/main_memory.sv */
module main_memory #(
    parameter int MEM_LATENCY     = 4,
    parameter int MEM_BLOCKS_LOG2 = 10
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req,
    input  logic                                   we,
    input  logic [cache_pkg::block_addr_width-1:0] addr,
    input  logic [cache_pkg::block_bits-1:0]       wblock,
    output logic                                   done,
    output logic [cache_pkg::block_bits-1:0]       rblock
);

    localparam int depth     = 1 << MEM_BLOCKS_LOG2;
    localparam int cnt_width = $clog2(MEM_LATENCY + 1);

    logic [cache_pkg::block_bits-1:0] blocks [depth];
    logic [cnt_width-1:0]             count;
    logic [MEM_BLOCKS_LOG2-1:0]       slot;
    logic                             ready;

    // Upper block address bits are ignored
    assign slot  = addr[MEM_BLOCKS_LOG2-1:0];
    assign ready = req && !done && (count == cnt_width'(MEM_LATENCY - 1));

    //////////////////////////////
    // Latency counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= ready;
            if (!req || done || ready) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Access happens on the edge that raises done
    always_ff @(posedge clk) begin
        if (ready) begin
            if (we) begin
                blocks[slot] <= wblock;
            end
            rblock <= blocks[slot];
        end
    end

endmodule

/* source/cache_system.sv */
module cache_system #(
    parameter int MEM_LATENCY     = 4,
    parameter int MEM_BLOCKS_LOG2 = 10
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             core0_req,
    input  logic                             core0_we,
    input  logic [3:0]                       core0_byte_en,
    input  logic [cache_pkg::addr_width-1:0] core0_addr,
    input  logic [31:0]                      core0_wdata,
    output logic                             core0_done,
    output logic [31:0]                      core0_rdata,

    input  logic                             core1_req,
    input  logic                             core1_we,
    input  logic [3:0]                       core1_byte_en,
    input  logic [cache_pkg::addr_width-1:0] core1_addr,
    input  logic [31:0]                      core1_wdata,
    output logic                             core1_done,
    output logic [31:0]                      core1_rdata
);

    // Cache to arbiter buses
    logic                                   c0_req, c1_req;
    logic                                   c0_we, c1_we;
    logic [cache_pkg::block_addr_width-1:0] c0_addr, c1_addr;
    logic [cache_pkg::block_bits-1:0]       c0_wblock, c1_wblock;
    logic                                   c0_done, c1_done;
    logic [cache_pkg::block_bits-1:0]       c0_rblock, c1_rblock;

    // Arbiter to memory
    logic                                   m_req;
    logic                                   m_we;
    logic [cache_pkg::block_addr_width-1:0] m_addr;
    logic [cache_pkg::block_bits-1:0]       m_wblock;
    logic                                   m_done;
    logic [cache_pkg::block_bits-1:0]       m_rblock;

    cache_ctrl u_cache0 (
        .clk (clk), .rst (rst),
        .req (core0_req), .we (core0_we), .byte_en (core0_byte_en),
        .addr (core0_addr), .wdata (core0_wdata),
        .done (core0_done), .rdata (core0_rdata),
        .mem_req (c0_req), .mem_we (c0_we), .mem_addr (c0_addr),
        .mem_wblock (c0_wblock), .mem_done (c0_done), .mem_rblock (c0_rblock)
    );

    cache_ctrl u_cache1 (
        .clk (clk), .rst (rst),
        .req (core1_req), .we (core1_we), .byte_en (core1_byte_en),
        .addr (core1_addr), .wdata (core1_wdata),
        .done (core1_done), .rdata (core1_rdata),
        .mem_req (c1_req), .mem_we (c1_we), .mem_addr (c1_addr),
        .mem_wblock (c1_wblock), .mem_done (c1_done), .mem_rblock (c1_rblock)
    );

    mem_arbiter u_arbiter (
        .clk (clk), .rst (rst),
        .cache0_req (c0_req), .cache0_we (c0_we), .cache0_addr (c0_addr),
        .cache0_wblock (c0_wblock), .cache0_done (c0_done), .cache0_rblock (c0_rblock),
        .cache1_req (c1_req), .cache1_we (c1_we), .cache1_addr (c1_addr),
        .cache1_wblock (c1_wblock), .cache1_done (c1_done), .cache1_rblock (c1_rblock),
        .mem_req (m_req), .mem_we (m_we), .mem_addr (m_addr),
        .mem_wblock (m_wblock), .mem_done (m_done), .mem_rblock (m_rblock)
    );

    main_memory #(
        .MEM_LATENCY     (MEM_LATENCY),
        .MEM_BLOCKS_LOG2 (MEM_BLOCKS_LOG2)
    ) u_memory (
        .clk (clk), .rst (rst),
        .req (m_req), .we (m_we), .addr (m_addr), .wblock (m_wblock),
        .done (m_done), .rblock (m_rblock)
    );

endmodule

/* verification/cache_system_tb.sv */
module cache_system_tb;

    localparam string       data_file    = "verification/cache_system_testdata.txt";
    localparam int          mem_latency  = 4;
    localparam int          reset_cycles = 8;
    localparam int          lines        = 1 << cache_pkg::index_width;
    localparam logic [31:0] lfsr_seed    = 32'hacde;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsr_taps    = 32'h80200003;

    logic clk = 1'b0;
    logic rst;

    logic                             core0_req;
    logic                             core0_we;
    logic [3:0]                       core0_byte_en;
    logic [cache_pkg::addr_width-1:0] core0_addr;
    logic [31:0]                      core0_wdata;
    logic                             core0_done;
    logic [31:0]                      core0_rdata;

    logic                             core1_req;
    logic                             core1_we;
    logic [3:0]                       core1_byte_en;
    logic [cache_pkg::addr_width-1:0] core1_addr;
    logic [31:0]                      core1_wdata;
    logic                             core1_done;
    logic [31:0]                      core1_rdata;

    // Entry layout is op, addr, byte_en, wdata, expected rdata
    logic [98:0] port0_entries [$];
    logic [98:0] port1_entries [$];

    int data_errors   = 0;
    int timing_errors = 0;
    int other_errors  = 0;
    int cycle_count   = 0;
    int cycle_limit   = 0;

    always #20 clk = ~clk;

    cache_system #(
        .MEM_LATENCY     (mem_latency),
        .MEM_BLOCKS_LOG2 (10)
    ) cache_system_i (
        .clk (clk), .rst (rst),
        .core0_req (core0_req), .core0_we (core0_we), .core0_byte_en (core0_byte_en),
        .core0_addr (core0_addr), .core0_wdata (core0_wdata),
        .core0_done (core0_done), .core0_rdata (core0_rdata),
        .core1_req (core1_req), .core1_we (core1_we), .core1_byte_en (core1_byte_en),
        .core1_addr (core1_addr), .core1_wdata (core1_wdata),
        .core1_done (core1_done), .core1_rdata (core1_rdata)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    task automatic load_entries();
        int          fd;
        int          code;
        int          fields;
        string       text;
        logic [31:0] port;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] wdata;
        logic [31:0] exp_data;

        fd = $fopen(data_file, "r");
        if (fd == 0) begin
            $display("Could not open test data file %s", data_file);
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                code   = $fgets(text, fd);
                fields = $sscanf(text, "%h %h %h %h %h %h", port, op, addr, be, wdata, exp_data);
                // Comment and blank lines give fewer than six fields
                if (code > 0 && fields == 6) begin
                    if (port == 0) begin
                        port0_entries.push_back({op[0], addr[29:0], be[3:0], wdata, exp_data});
                    end else if (port == 1) begin
                        port1_entries.push_back({op[0], addr[29:0], be[3:0], wdata, exp_data});
                    end else begin
                        $display("Test data names port %0d, which does not exist", port);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_request(input int port, input logic req, input logic we,
                                 input logic [3:0] be,
                                 input logic [cache_pkg::addr_width-1:0] addr,
                                 input logic [31:0] wdata);
        if (port == 0) begin
            core0_req     <= req;
            core0_we      <= we;
            core0_byte_en <= be;
            core0_addr    <= addr;
            core0_wdata   <= wdata;
        end else begin
            core1_req     <= req;
            core1_we      <= we;
            core1_byte_en <= be;
            core1_addr    <= addr;
            core1_wdata   <= wdata;
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d data, %0d timing, %0d other",
                 data_errors, timing_errors, other_errors);
    endtask

    //////////////////////////////
    // One core port
    //////////////////////////////
    task automatic run_port(input int port);
        logic [98:0]                       entry;
        logic                              op;
        logic [cache_pkg::addr_width-1:0]  addr;
        logic [3:0]                        be;
        logic [31:0]                       wdata;
        logic [31:0]                       exp_data;
        logic [31:0]                       got;
        logic [31:0]                       lfsr;
        logic [cache_pkg::tag_width-1:0]   tag;
        logic [cache_pkg::index_width-1:0] index;
        logic [cache_pkg::tag_width-1:0]   line_tag [lines];
        logic                              line_known [lines];
        logic                              expect_hit;
        logic                              done_now;
        int                                total;
        int                                gap;
        int                                waited;

        total = (port == 0) ? port0_entries.size() : port1_entries.size();
        lfsr  = lfsr_seed;
        for (int i = 0; i < lines; i++) begin
            line_known[i] = 1'b0;
        end

        for (int n = 0; n < total; n++) begin
            entry    = (port == 0) ? port0_entries[n] : port1_entries[n];
            op       = entry[98];
            addr     = entry[97:68];
            be       = entry[67:64];
            wdata    = entry[63:32];
            exp_data = entry[31:0];
            index    = addr[cache_pkg::offset_width +: cache_pkg::index_width];
            tag      = addr[cache_pkg::addr_width-1 -: cache_pkg::tag_width];

            // Direct mapped with write allocate, so the last tag seen at an index is resident
            expect_hit        = line_known[index] && (line_tag[index] == tag);
            line_known[index] = 1'b1;
            line_tag[index]   = tag;

            // Two LFSR bits give 0 to 3 idle cycles
            gap = 0;
            repeat (2) begin
                gap  = (gap << 1) | int'(lfsr[0]);
                lfsr = lfsr_step(lfsr);
            end
            if (gap > 0) begin
                drive_request(port, 1'b0, 1'b0, 4'h0, '0, '0);
                repeat (gap) begin
                    @(posedge clk);
                    done_now = (port == 0) ? core0_done : core1_done;
                    assert (done_now === 1'b0)
                    else begin
                        $display("Port %0d raised done with no request pending", port);
                        other_errors++;
                    end
                end
            end
            drive_request(port, 1'b1, op, be, addr, wdata);

            waited   = 0;
            done_now = 1'b0;
            while (done_now !== 1'b1) begin
                @(posedge clk);
                waited++;
                done_now = (port == 0) ? core0_done : core1_done;
            end
            got = (port == 0) ? core0_rdata : core1_rdata;

            // Hit answers one cycle after the sampling edge, a miss goes to memory first
            assert (expect_hit ? (waited == 2) : (waited > 2))
            else begin
                $display("Port %0d %s at %h finished after %0d cycles, too %s for a %s",
                         port, op ? "write" : "read", addr, waited,
                         expect_hit ? "slow" : "fast", expect_hit ? "hit" : "miss");
                timing_errors++;
            end
            if (!op) begin
                assert (got === exp_data)
                else begin
                    $display("FAILED core%0d_rdata at addr %h: expected %h, got %h",
                             port, addr, exp_data, got);
                    data_errors++;
                end
            end
        end
        drive_request(port, 1'b0, 1'b0, 4'h0, '0, '0);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("Timeout: requests still pending after %0d cycles", cycle_limit);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        core0_req     = 1'b0;
        core0_we      = 1'b0;
        core0_byte_en = 4'h0;
        core0_addr    = '0;
        core0_wdata   = '0;
        core1_req     = 1'b0;
        core1_we      = 1'b0;
        core1_byte_en = 4'h0;
        core1_addr    = '0;
        core1_wdata   = '0;

        load_entries();
        if (port0_entries.size() + port1_entries.size() == 0) begin
            $display("No requests found in the test data");
            other_errors++;
        end else begin
            // Worst case per request, summed over both ports
            cycle_limit = reset_cycles + (port0_entries.size() + port1_entries.size()) *
                          (3 + 2 * mem_latency + 8);
        end

        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            // State is unknown before the first reset edge
            if (c > 0) begin
                assert (core0_done === 1'b0 && core1_done === 1'b0)
                else begin
                    $display("A done output was high while reset was held");
                    other_errors++;
                end
            end
        end
        rst <= 1'b0;

        if (other_errors == 0) begin
            fork
                run_port(0);
                run_port(1);
            join
        end

        report_counts();
        if (data_errors + timing_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/cache_system_testdata.txt */
// Columns in hex: port op addr byte_en wdata expected_rdata
// op 1 is a write, op 0 a read; expected_rdata counts for reads only
// Port 0, tags 1 and 2 share index 4, tag 1 also at index 5
0 1 00000420 f 11111111 00000000
0 0 00000420 f 00000000 11111111
0 1 00000421 f 22222222 00000000
0 1 00000420 3 aaaabbbb 00000000
0 0 00000420 f 00000000 1111bbbb
0 1 00000423 f 33333333 00000000
0 1 00000423 9 44aaaa55 00000000
0 0 00000423 f 00000000 44333355
0 1 00000820 f 55555555 00000000
0 1 00000822 f 66666666 00000000
0 0 00000420 f 00000000 1111bbbb
0 0 00000421 f 00000000 22222222
0 0 00000820 f 00000000 55555555
0 0 00000822 f 00000000 66666666
0 1 0000042a f 77777777 00000000
0 0 0000042a f 00000000 77777777
0 0 00000423 f 00000000 44333355
// Port 1, tags 5 and 6 share index 4, tag 5 also at index 9
1 1 00001420 f 89abcdef 00000000
1 1 00001425 f 01234567 00000000
1 1 00001820 f deadbeef 00000000
1 1 00001827 f cafef00d 00000000
1 0 00001420 f 00000000 89abcdef
1 0 00001425 f 00000000 01234567
1 1 00001425 6 00ffff00 00000000
1 0 00001425 f 00000000 01ffff67
1 0 00001827 f 00000000 cafef00d
1 0 00001820 f 00000000 deadbeef
1 1 00001449 f 13579bdf 00000000
1 0 00001449 f 00000000 13579bdf
1 0 00001425 f 00000000 01ffff67
1 0 00001420 f 00000000 89abcdef

/* compile.f */
source/cache_pkg.sv
source/cache_word_ram.sv
source/cache_line_store.sv
source/cache_ctrl.sv
source/mem_arbiter.sv
source/main_memory.sv
source/cache_system.sv
verification/cache_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_system_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
DATA    := verification/cache_system_testdata.txt

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
